/* Bender.yml */
package:
  name: board_glue

sources:
  - include_dirs:
      - source
    files:
      - source/board_pkg.sv
      - source/board_settings.sv
      - source/board_reset.sv
      - source/board_inputs.sv
      - source/board_top.sv
  - target: simulation
    files:
      - tb/board_assertions.sv
      - tb/board_tb.sv

/* source/board_inputs.sv */
/*
    Input mapper
    Synchronises the board joysticks, merges the keyboard, applies
    rotation and polarity, and keeps the pause and layer toggles
*/
`timescale 1ns/1ps
`include "board_params.svh"

module board_inputs (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic                      rot_en,
    input  board_pkg::board_joy_t     joy1_raw,
    input  board_pkg::board_joy_t     joy2_raw,
    input  board_pkg::key_state_t     keys,
    output board_pkg::game_inputs_t   game,
    output logic                      game_pause,
    output board_pkg::gfx_en_t        gfx_en,
    output logic                      soft_rst
);

    import board_pkg::*;

    localparam logic         INV      = `BOARD_INPUTS_ACTIVE_LOW;
    localparam game_inputs_t INV_MASK = {$bits(game_inputs_t){INV}};

    board_joy_t   joy1_sync;
    board_joy_t   joy2_sync;
    game_inputs_t game_nx;    // Active high, before inversion
    logic         joy_pause;
    logic         last_pause;
    logic         last_joypause;
    logic         last_reset;
    gfx_en_t      last_gfx;

    // Quarter turn on the four direction bits only
    function automatic game_joy_t apply_rotation(input game_joy_t joy_in, input logic rot);
        game_joy_t rotated;
        rotated = {joy_in[`BOARD_GAME_JOY_W-1:4], joy_in[0], joy_in[1], joy_in[3], joy_in[2]};
        return rot ? rotated : joy_in;
    endfunction

    always_ff @(posedge clk_sys) begin
        joy1_sync <= joy1_raw;
        joy2_sync <= joy2_raw;
    end

    assign joy_pause = joy1_sync[`BOARD_PAUSE_BIT] | joy2_sync[`BOARD_PAUSE_BIT];

    always_comb begin
        game_nx.joy1    = apply_rotation(joy1_sync[`BOARD_GAME_JOY_W-1:0] | keys.joy1, rot_en);
        game_nx.joy2    = apply_rotation(joy2_sync[`BOARD_GAME_JOY_W-1:0] | keys.joy2, rot_en);
        game_nx.coin    = {joy2_sync[`BOARD_COIN_BIT], joy1_sync[`BOARD_COIN_BIT]} | keys.coin;
        game_nx.start   = {joy1_sync[`BOARD_START2_BIT], joy1_sync[`BOARD_START1_BIT]}
                        | {joy2_sync[`BOARD_START2_BIT], joy2_sync[`BOARD_START1_BIT]}
                        | keys.start;
        game_nx.service = keys.service;
    end

    // Output register with polarity applied
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game <= INV_MASK;   // All inactive
        end else begin
            game <= game_nx ^ INV_MASK;
        end
    end

    // Edge-triggered state
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_pause    <= 1'b0;
            last_joypause <= 1'b0;
            last_reset    <= 1'b0;
            last_gfx      <= '0;
            game_pause    <= 1'b0;
            gfx_en        <= '1;    // Every layer shown
            soft_rst      <= 1'b0;
        end else begin
            last_pause    <= keys.pause;
            last_joypause <= joy_pause;
            last_reset    <= keys.reset;
            last_gfx      <= keys.gfx;
            soft_rst      <= keys.reset & ~last_reset;   // Single pulse
            gfx_en        <= gfx_en ^ (keys.gfx & ~last_gfx);
            if ((keys.pause && !last_pause) || (joy_pause && !last_joypause)) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

/* source/board_params.svh */
/*
    Board glue constants
    Widths, bit positions and hold lengths shared by the settings,
    reset and input blocks
*/
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// Joystick words
`define BOARD_JOY_W             16
`define BOARD_GAME_JOY_W        10

// Extra buttons push start, coin and pause up
`define BOARD_THREE_BUTTONS     0
`define BOARD_START1_BIT        (6 + `BOARD_THREE_BUTTONS)
`define BOARD_START2_BIT        (7 + `BOARD_THREE_BUTTONS)
`define BOARD_COIN_BIT          (8 + `BOARD_THREE_BUTTONS)
`define BOARD_PAUSE_BIT         (9 + `BOARD_THREE_BUTTONS)

`define BOARD_INPUTS_ACTIVE_LOW 1'b1   // Game sees low as pressed

// OSD status word
`define BOARD_STATUS_W          32
`define BOARD_ST_ROT_BIT        2
`define BOARD_ST_FLIP_BIT       3
`define BOARD_ST_TEST_BIT       4

`define BOARD_GFX_W             4
`define BOARD_GAME_RST_HOLD     16     // Cycles after the last trigger

`endif

/* source/board_pkg.sv */
/*
    Board glue types
    Vector typedefs and the structs passed between the blocks
*/
`include "board_params.svh"

package board_pkg;

    typedef logic [`BOARD_JOY_W-1:0]      board_joy_t;  // Raw board joystick
    typedef logic [`BOARD_GAME_JOY_W-1:0] game_joy_t;
    typedef logic [1:0]                   pair_t;       // Player 2 in the high bit
    typedef logic [`BOARD_GFX_W-1:0]      gfx_en_t;
    typedef logic [4:0]                   rst_cnt_t;    // Must hold BOARD_GAME_RST_HOLD

    typedef struct packed {
        logic rot_en;
        logic flip;
        logic test;
    } board_settings_t;

    // Decoded keyboard, all active high
    typedef struct packed {
        game_joy_t joy1;
        game_joy_t joy2;
        pair_t     start;
        pair_t     coin;
        logic      reset;
        logic      pause;
        logic      service;
        gfx_en_t   gfx;
    } key_state_t;

    // As the game core sees them, polarity already applied
    typedef struct packed {
        game_joy_t joy1;
        game_joy_t joy2;
        pair_t     coin;
        pair_t     start;
        logic      service;
    } game_inputs_t;

endpackage

/* source/board_reset.sv */
/*
    Game reset sequencer
    Stretches every reset trigger by a fixed hold count and builds a
    two-stage active-low copy of the stretched reset
*/
`timescale 1ns/1ps
`include "board_params.svh"

module board_reset (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic flip,
    output logic game_rst,
    output logic game_rst_n
);

    import board_pkg::*;

    logic     last_flip;
    logic     trigger;
    rst_cnt_t hold_cnt;
    logic     pre_game_rst_n;

    // Screen flip change restarts the game like a reset
    assign trigger = rst | downloading | rst_req | soft_rst | (flip != last_flip);

    always_ff @(posedge clk_sys) begin
        last_flip <= flip;
    end

    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            hold_cnt <= '0;          // Restart the hold
            game_rst <= 1'b1;
        end else if (hold_cnt != rst_cnt_t'(`BOARD_GAME_RST_HOLD)) begin
            hold_cnt <= hold_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

    // Active-low copy
    // Falls right after game_rst rises, rises two cycles after it falls
    always_ff @(posedge clk_sys) begin
        if (rst || game_rst) begin
            pre_game_rst_n <= 1'b0;
            game_rst_n     <= 1'b0;
        end else begin
            pre_game_rst_n <= 1'b1;
            game_rst_n     <= pre_game_rst_n;
        end
    end

endmodule

/* source/board_settings.sv */
/*
    Settings register
    Picks rotation, flip and test mode out of the OSD status word
    and holds them for the rest of the board
*/
`timescale 1ns/1ps
`include "board_params.svh"

module board_settings (
    input  logic                         clk_sys,
    input  logic                         rst,
    input  logic [`BOARD_STATUS_W-1:0]   status,
    output board_pkg::board_settings_t   settings
);

    // One cycle of latency from the OSD
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            settings <= '0;
        end else begin
            settings.rot_en <= status[`BOARD_ST_ROT_BIT];
            settings.flip   <= status[`BOARD_ST_FLIP_BIT];   // Change restarts the game
            settings.test   <= status[`BOARD_ST_TEST_BIT];
        end
    end

endmodule

/* source/board_top.sv */
/*
    Board input and reset glue
    Settings register, game reset sequencer and input mapper
*/
`timescale 1ns/1ps
`include "board_params.svh"

module board_top (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  logic [`BOARD_STATUS_W-1:0] status,
    input  logic                       rst_req,
    input  logic                       downloading,
    input  board_pkg::board_joy_t      joy1_raw,
    input  board_pkg::board_joy_t      joy2_raw,
    input  board_pkg::key_state_t      keys,
    output board_pkg::game_inputs_t    game,
    output logic                       game_pause,
    output board_pkg::gfx_en_t         gfx_en,
    output logic                       game_rst,
    output logic                       game_rst_n,
    output logic                       dip_flip,
    output logic                       dip_test
);

    import board_pkg::*;

    board_settings_t settings;
    logic            soft_rst;   // Keyboard reset pulse

    board_settings u_settings (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .status      ( status      ),
        .settings    ( settings    )
    );

    board_reset u_reset (
        .clk_sys     ( clk_sys       ),
        .rst         ( rst           ),
        .downloading ( downloading   ),
        .rst_req     ( rst_req       ),
        .soft_rst    ( soft_rst      ),
        .flip        ( settings.flip ),
        .game_rst    ( game_rst      ),
        .game_rst_n  ( game_rst_n    )
    );

    board_inputs u_inputs (
        .clk_sys     ( clk_sys         ),
        .rst         ( rst             ),
        .rot_en      ( settings.rot_en ),
        .joy1_raw    ( joy1_raw        ),
        .joy2_raw    ( joy2_raw        ),
        .keys        ( keys            ),
        .game        ( game            ),
        .game_pause  ( game_pause      ),
        .gfx_en      ( gfx_en          ),
        .soft_rst    ( soft_rst        )
    );

    assign dip_flip = settings.flip;
    assign dip_test = settings.test;

endmodule

/* tb/board_assertions.sv */
/*
    Board glue assertions
    Reset ordering, soft reset pulse width and layer enables after reset
*/
`timescale 1ns/1ps

module board_assertions (
    input  logic               clk_sys,
    input  logic               rst,
    input  logic               game_rst,
    input  logic               game_rst_n,
    input  logic               soft_rst,
    input  board_pkg::gfx_en_t gfx_en
);

    import board_pkg::*;

    // Active-low copy comes back only after two low cycles of the game reset
    a_rst_n_low : assert property (@(posedge clk_sys)
        $rose(game_rst_n) |-> !$past(game_rst) && !$past(game_rst, 2))
        else $error("game_rst_n high while game_rst held");

    a_soft_pulse : assert property (@(posedge clk_sys) disable iff (rst) soft_rst |=> !soft_rst)
        else $error("soft_rst lasted more than one cycle");

    // Every layer on right after reset
    a_gfx_reset : assert property (@(posedge clk_sys) $fell(rst) |-> gfx_en == '1)
        else $error("gfx_en not all ones after reset");

endmodule

bind board_top board_assertions u_assertions (
    .clk_sys    ( clk_sys    ),
    .rst        ( rst        ),
    .game_rst   ( game_rst   ),
    .game_rst_n ( game_rst_n ),
    .soft_rst   ( soft_rst   ),
    .gfx_en     ( gfx_en     )
);

/* tb/board_tb.sv */
/*
    Board glue testbench
    Table driven input mapping, pause and layer toggles, game reset timing
*/
`timescale 1ns/1ps
`include "board_params.svh"

module board_tb;

    import board_pkg::*;

    typedef struct packed {
        board_joy_t   joy1;
        board_joy_t   joy2;
        key_state_t   keys;
        logic [31:0]  status;
        game_inputs_t exp;
    } row_t;

    localparam int NROWS = 10;
    localparam int HOLD  = `BOARD_GAME_RST_HOLD;

    logic         clk_sys = 1'b0;
    logic         rst;
    logic [31:0]  status;
    logic         rst_req;
    logic         downloading;
    board_joy_t   joy1_raw;
    board_joy_t   joy2_raw;
    key_state_t   keys;
    game_inputs_t game;
    logic         game_pause;
    gfx_en_t      gfx_en;
    logic         game_rst;
    logic         game_rst_n;
    logic         dip_flip;
    logic         dip_test;
    row_t         table_rows [NROWS];
    logic         pause_was;
    gfx_en_t      gfx_was;

    board_top dut (.*);

    always #5 clk_sys = ~clk_sys;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Some tests failed");
        $fatal(1, "timeout");
    endtask

    // Game view built straight from the mapping rules, active high then inverted
    function automatic game_inputs_t expect_game(board_joy_t j1, board_joy_t j2,
                                                 key_state_t k, logic rot);
        game_inputs_t g;
        game_joy_t    m1;
        game_joy_t    m2;
        m1 = j1[9:0] | k.joy1;
        m2 = j2[9:0] | k.joy2;
        if (rot) begin
            m1 = {m1[9:4], m1[0], m1[1], m1[3], m1[2]};
            m2 = {m2[9:4], m2[0], m2[1], m2[3], m2[2]};
        end
        g.joy1    = m1;
        g.joy2    = m2;
        g.coin    = {j2[8], j1[8]} | k.coin;
        g.start   = {j1[7] | j2[7], j1[6] | j2[6]} | k.start;
        g.service = k.service;
        return ~g;
    endfunction

    function automatic row_t make_row(board_joy_t j1, board_joy_t j2, key_state_t k,
                                      logic rot);
        row_t r;
        r.joy1   = j1;
        r.joy2   = j2;
        r.keys   = k;
        r.status = 32'(rot) << 2;
        r.exp    = expect_game(j1, j2, k, rot);
        return r;
    endfunction

    task automatic build_table;
        key_state_t k;
        k = '0;
        table_rows[0] = make_row(16'h0000, 16'h0000, k, 1'b0);    // Idle
        table_rows[1] = make_row(16'h0005, 16'h000a, k, 1'b0);
        table_rows[2] = make_row(16'h0005, 16'h000a, k, 1'b1);    // Rotated
        table_rows[3] = make_row(16'h0140, 16'h0080, k, 1'b0);    // Coin and start on joysticks
        k.coin    = 2'b10;
        k.start   = 2'b01;
        k.service = 1'b1;
        table_rows[4] = make_row(16'h0000, 16'h0000, k, 1'b0);
        k         = '0;
        k.joy1    = 10'h021;
        k.joy2    = 10'h204;
        table_rows[5] = make_row(16'h0012, 16'h0000, k, 1'b1);   // Key merge
        for (int i = 6; i < NROWS; i++) begin
            k      = '0;
            k.joy1 = 10'($urandom());
            table_rows[i] = make_row(16'($urandom()) & 16'hfdff, 16'($urandom()) & 16'hfdff,
                                     k, 1'($urandom()));
        end
    endtask

    task automatic wait_game_rst_high;
        int n;
        n = 0;
        do begin
            @(negedge clk_sys);
            n++;
            if (n > 20) stop_on_timeout("game_rst to rise");
        end while (!game_rst);
    endtask

    // Counts falling edges from now until release of both resets
    task automatic measure_release(input int exp_fall);
        int n;
        n = 0;
        do begin
            @(negedge clk_sys);
            n++;
            if (n > 100) stop_on_timeout("game_rst to fall");
        end while (game_rst);
        check("game_rst hold", n, exp_fall);
        n = 0;
        do begin
            @(negedge clk_sys);
            n++;
            if (n > 10) stop_on_timeout("game_rst_n to rise");
        end while (!game_rst_n);
        check("game_rst_n delay", n, 2);
    endtask

    initial begin
        rst = 1'b1;
        status = '0;
        rst_req = 1'b0;
        downloading = 1'b0;
        joy1_raw = '0;
        joy2_raw = '0;
        keys = '0;
        void'($urandom(32'ha0d7_2329));
        build_table();

        repeat (8) @(negedge clk_sys);
        check("gfx_en", gfx_en, 4'hf);
        check("game_pause", game_pause, 0);
        check("game", game, {$bits(game_inputs_t){1'b1}});
        check("game_rst_n", game_rst_n, 0);
        check("dip_flip", dip_flip, 0);
        check("dip_test", dip_test, 0);
        rst = 1'b0;
        measure_release(HOLD + 1);

        for (int i = 0; i < NROWS; i++) begin
            joy1_raw = table_rows[i].joy1;
            joy2_raw = table_rows[i].joy2;
            keys     = table_rows[i].keys;
            status   = table_rows[i].status;
            repeat (3) @(negedge clk_sys);
            check("game", game, table_rows[i].exp);
        end
        joy1_raw = '0;
        joy2_raw = '0;
        keys     = '0;
        repeat (3) @(negedge clk_sys);

        // Pause from keys, joystick 1 and joystick 2, level held each time
        for (int src = 0; src < 3; src++) begin
            pause_was = game_pause;
            if (src == 0) keys.pause = 1'b1;
            if (src == 1) joy1_raw[`BOARD_PAUSE_BIT] = 1'b1;
            if (src == 2) joy2_raw[`BOARD_PAUSE_BIT] = 1'b1;
            repeat (5) @(negedge clk_sys);
            check("game_pause", game_pause, !pause_was);
            keys     = '0;
            joy1_raw = '0;
            joy2_raw = '0;
            repeat (4) @(negedge clk_sys);
            check("game_pause", game_pause, !pause_was);
        end

        for (int b = 0; b < `BOARD_GFX_W; b++) begin
            gfx_was  = gfx_en;
            keys.gfx = gfx_en_t'(1 << b);
            repeat (4) @(negedge clk_sys);
            check("gfx_en", gfx_en, gfx_was ^ gfx_en_t'(1 << b));
            keys.gfx = '0;
            repeat (2) @(negedge clk_sys);
        end

        keys.reset = 1'b1;       // Keyboard reset
        wait_game_rst_high();
        keys.reset = 1'b0;
        measure_release(HOLD + 1);

        rst_req = 1'b1;
        wait_game_rst_high();
        rst_req = 1'b0;
        measure_release(HOLD + 1);

        downloading = 1'b1;
        wait_game_rst_high();
        downloading = 1'b0;
        measure_release(HOLD + 1);

        status[`BOARD_ST_FLIP_BIT] = 1'b1;
        wait_game_rst_high();
        measure_release(HOLD + 1);
        check("dip_flip", dip_flip, 1);
        status[`BOARD_ST_FLIP_BIT] = 1'b0;   // Back again is also a change
        wait_game_rst_high();
        measure_release(HOLD + 1);

        // Test mode only reaches the dip output, no game reset
        status[`BOARD_ST_TEST_BIT] = 1'b1;
        repeat (2) @(negedge clk_sys);
        check("dip_test", dip_test, 1);
        check("game_rst", game_rst, 0);
        status[`BOARD_ST_TEST_BIT] = 1'b0;
        repeat (2) @(negedge clk_sys);
        check("dip_test", dip_test, 0);

        // Second request in the middle of the hold restarts it
        rst_req = 1'b1;
        wait_game_rst_high();
        rst_req = 1'b0;
        repeat (8) begin
            @(negedge clk_sys);
            check("game_rst", game_rst, 1);
        end
        rst_req = 1'b1;
        @(negedge clk_sys);
        rst_req = 1'b0;
        measure_release(HOLD + 1);

        $display("All tests passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/board_pkg.sv
source/board_settings.sv
source/board_reset.sv
source/board_inputs.sv
source/board_top.sv
tb/board_assertions.sv
tb/board_tb.sv
